// File: flist.f
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_pointers.sv
verilog/rob_entry_table.sv
verilog/rob_retire.sv
verilog/rob_store_port.sv
verilog/rob_top.sv
tb/rob_props.sv
tb/tb_rob.sv

// File: Bender.yml
package:
  name: rob

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rob_pkg.sv
      - verilog/rob_pointers.sv
      - verilog/rob_entry_table.sv
      - verilog/rob_retire.sv
      - verilog/rob_store_port.sv
      - verilog/rob_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/rob_props.sv
      - tb/tb_rob.sv

// File: tb/tb_rob.sv
`include "rob_consts.svh"

module tb_rob import rob_pkg::*; ();

    localparam int path_alu = 0;
    localparam int path_load = 1;
    localparam int path_store = 2;
    localparam int log_commit = 0;
    localparam int log_bus = 1;
    localparam int log_flush = 2;

    logic                  alu_broadcast = 1'b0;
    logic                  reset = 1'b1;
    logic                  alloc_valid = 1'b0;
    rob_op_e               alloc_op = OP_REG;
    logic [`REG_IDX_W-1:0] alloc_rd = '0;
    logic [`XLEN-1:0]      alloc_pc = '0;
    logic                  alloc_pred_taken = 1'b0;
    logic [`ROB_TAG_W-1:0] rs1_tag = '0;
    logic [`ROB_TAG_W-1:0] rs2_tag = '0;
    logic                  alu_valid = 1'b0;
    logic [`ROB_TAG_W-1:0] alu_tag = '0;
    logic [`XLEN-1:0]      alu_value = '0;
    logic [`XLEN-1:0]      alu_target = '0;
    logic                  load_valid = 1'b0;
    logic [`ROB_TAG_W-1:0] load_tag = '0;
    logic [`XLEN-1:0]      load_value = '0;
    logic                  store_valid = 1'b0;
    logic [`ROB_TAG_W-1:0] store_tag = '0;
    logic [`XLEN-1:0]      store_addr = '0;
    logic [`XLEN-1:0]      store_data = '0;
    logic                  wb_ack = 1'b0;
    logic [`ROB_TAG_W-1:0] alloc_tag;
    logic [`ROB_TAG_W-1:0] reg_tag;
    logic [`REG_IDX_W-1:0] reg_rd;
    logic                  full, rs1_ready, rs2_ready, reg_we, flush, wb_cyc, wb_stb, wb_we;
    logic [`XLEN-1:0]      rs1_value, rs2_value, reg_value, redirect_pc, wb_adr, wb_dat_w;
    logic [3:0]            wb_sel;

    // expected register commit per tag
    logic [`REG_IDX_W-1:0] exp_rd    [`ROB_DEPTH];
    logic [`XLEN-1:0]      exp_value [`ROB_DEPTH];
    // observed events: {tag, rd, value}, {adr, sel, data}, redirect pc
    logic [40:0]           commit_q [$];
    logic [67:0]           bus_q [$];
    logic [`XLEN-1:0]      flush_q [$];
    int                    errors = 0;
    int                    tests = 0;
    int                    err_at_start;
    string                 cur_test;

    rob_top u_rob_top (.*);

    always #2 alu_broadcast = ~alu_broadcast;

    // memory side, ack after 0 to 3 extra cycles
    always begin
        @(negedge alu_broadcast);
        if (wb_stb && !wb_ack) begin
            repeat (($urandom % 4) + 1) @(posedge alu_broadcast);
            wb_ack <= 1'b1;
            @(posedge alu_broadcast);
            wb_ack <= 1'b0;
        end
    end

    // log outputs mid-cycle where they are stable
    always @(negedge alu_broadcast) begin
        if (!reset) begin
            if (reg_we) commit_q.push_back({reg_tag, reg_rd, reg_value});
            if (wb_stb && wb_ack) bus_q.push_back({wb_adr, wb_sel, wb_dat_w});
            if (flush) flush_q.push_back(redirect_pc);
            // younger entries wait for the store ack
            assert (!(reg_we && wb_cyc)) else begin
                $display("%s: register commit while a store was still on the bus", cur_test);
                errors++;
            end
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %s", cur_test, (errors == err_at_start) ? "ok" : "failed");
    endtask

    task automatic allocate(input rob_op_e op, input logic [4:0] rd, input logic [31:0] pc,
                            input logic pred);
        @(posedge alu_broadcast);
        alloc_valid      <= 1'b1;
        alloc_op         <= op;
        alloc_rd         <= rd;
        alloc_pc         <= pc;
        alloc_pred_taken <= pred;
        @(posedge alu_broadcast);
        alloc_valid <= 1'b0;
    endtask

    // a is value or store address, b is branch target or store data
    task automatic write_back(input int path, input logic [3:0] tag, input logic [31:0] a,
                              input logic [31:0] b);
        @(posedge alu_broadcast);
        alu_tag     <= tag;
        load_tag    <= tag;
        store_tag   <= tag;
        alu_value   <= a;
        load_value  <= a;
        store_addr  <= a;
        alu_target  <= b;
        store_data  <= b;
        alu_valid   <= (path == path_alu);
        load_valid  <= (path == path_load);
        store_valid <= (path == path_store);
        @(posedge alu_broadcast);
        alu_valid   <= 1'b0;
        load_valid  <= 1'b0;
        store_valid <= 1'b0;
    endtask

    task automatic lookup(input logic [3:0] tag, input logic ready, input logic [31:0] value);
        @(posedge alu_broadcast);
        rs1_tag <= tag;
        rs2_tag <= tag;
        @(negedge alu_broadcast);
        check("rs1_ready", ready, rs1_ready);
        check("rs2_ready", ready, rs2_ready);
        if (ready) begin
            check("rs1_value", value, rs1_value);
            check("rs2_value", value, rs2_value);
        end
    endtask

    function automatic int logged(input int kind);
        case (kind)
            log_commit: return commit_q.size();
            log_bus:    return bus_q.size();
            default:    return flush_q.size();
        endcase
    endfunction

    task automatic wait_until(input int kind, input int n, input string what);
        int cycles;
        cycles = 0;
        while (logged(kind) < n && cycles < 200) begin
            @(negedge alu_broadcast);
            cycles++;
        end
        if (logged(kind) < n) begin
            $display("%s: timed out waiting for %s", cur_test, what);
            errors++;
        end
    endtask

    task automatic check_commit(input int idx, input logic [3:0] tag);
        logic [40:0] rec;
        rec = commit_q[idx];
        check("reg_tag", tag, rec[40:37]);
        check("reg_rd", exp_rd[tag], rec[36:32]);
        check("reg_value", exp_value[tag], rec[31:0]);
    endtask

    // lanes from the lowest addressed byte up, data bytes in order
    function automatic logic [35:0] store_lanes(input rob_op_e op, input logic [31:0] addr,
                                                input logic [31:0] data);
        logic [3:0]  sel;
        logic [31:0] dat;
        int          low;
        int          size;
        case (op)
            OP_STORE_B: begin
                low  = addr[1:0];
                size = 1;
            end
            OP_STORE_H: begin
                low  = addr[1] * 2;
                size = 2;
            end
            default: begin
                low  = 0;
                size = 4;
            end
        endcase
        sel = '0;
        dat = '0;
        for (int i = low; i < low + size; i++) begin
            sel[i] = 1'b1;
            dat[8*i +: 8] = data[8*(i-low) +: 8];
        end
        return {sel, dat};
    endfunction

    initial begin
        int          order [3];
        int          j;
        int          tmp;
        int          total;
        rob_op_e     ops [3];
        logic [31:0] addr_w [3];
        logic [31:0] data_w [3];
        logic [67:0] rec;
        logic [35:0] lanes;
        logic [31:0] tgt;
        logic [3:0]  tag;
        void'($urandom(32'h677e_7938));

        start_test("reset_state");
        repeat (5) @(posedge alu_broadcast);
        reset <= 1'b0;
        @(negedge alu_broadcast);
        check("alloc_tag", 0, alloc_tag);
        check("full", 0, full);
        check("reg_we", 0, reg_we);
        check("flush", 0, flush);
        check("wb_cyc", 0, wb_cyc);
        end_test();

        start_test("lookup_and_order");
        for (int i = 0; i < 4; i++) begin
            exp_rd[i] = 5'($urandom);
            exp_value[i] = $urandom;
            allocate(OP_REG, exp_rd[i], 32'h100 + 4 * i, 1'b0);
        end
        // tags 1..3 shuffled, head entry last so nothing retires early
        order = '{1, 2, 3};
        for (int k = 0; k < 2; k++) begin
            j = k + ($urandom % (3 - k));
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < 3; k++) begin
            write_back(k % 2, order[k], exp_value[order[k]], 32'h0);
        end
        for (int t = 1; t < 4; t++) lookup(t, 1'b1, exp_value[t]);
        lookup(0, 1'b0, 32'h0);
        write_back($urandom % 2, 0, exp_value[0], 32'h0);
        wait_until(log_commit, 4, "register commits");
        for (int i = 0; i < 4; i++) check_commit(i, i);
        end_test();

        start_test("store_commit");
        ops = '{OP_STORE_B, OP_STORE_H, OP_STORE_W};
        for (int i = 0; i < 3; i++) allocate(ops[i], 5'd0, 32'h200 + 4 * i, 1'b0);
        exp_rd[7] = 5'($urandom);
        exp_value[7] = $urandom;
        allocate(OP_REG, exp_rd[7], 32'h20c, 1'b0);
        for (int i = 0; i < 3; i++) begin
            addr_w[i] = $urandom;
            data_w[i] = $urandom;
            write_back(path_store, 4 + i, addr_w[i], data_w[i]);
        end
        write_back(path_alu, 7, exp_value[7], 32'h0);
        wait_until(log_bus, 3, "store bus cycles");
        wait_until(log_commit, 5, "commit after the stores");
        for (int i = 0; i < 3; i++) begin
            rec = bus_q[i];
            lanes = store_lanes(ops[i], addr_w[i], data_w[i]);
            check("wb_adr", {addr_w[i][31:2], 2'b00}, rec[67:36]);
            check("wb_sel", lanes[35:32], rec[35:32]);
            check("wb_dat_w", lanes[31:0], rec[31:0]);
        end
        check_commit(4, 7);
        end_test();

        start_test("full");
        // head and tail both sit at 8 now
        for (int i = 0; i < 16; i++) begin
            tag = 4'(8 + i);
            exp_rd[tag] = 5'(i);
            exp_value[tag] = $urandom;
            allocate(OP_REG, exp_rd[tag], 32'h300 + 4 * i, 1'b0);
        end
        @(negedge alu_broadcast);
        check("full", 1, full);
        // would overwrite the head entry if taken
        allocate(OP_REG, 5'd31, 32'h340, 1'b0);
        @(negedge alu_broadcast);
        check("full", 1, full);
        check("alloc_tag", 8, alloc_tag);
        for (int i = 0; i < 16; i++) write_back(path_alu, 4'(8 + i), exp_value[4'(8 + i)], 0);
        wait_until(log_commit, 21, "commits of the full buffer");
        for (int i = 0; i < 16; i++) check_commit(5 + i, 4'(8 + i));
        check("alloc_tag", 8, alloc_tag);
        end_test();

        start_test("branch_check");
        // 8 predicted right, 9 mispredicted taken, 10 younger and must not retire
        tgt = $urandom;
        allocate(OP_BRANCH, 5'd0, 32'h2000, 1'b1);
        allocate(OP_BRANCH, 5'd0, 32'h2010, 1'b0);
        allocate(OP_REG, 5'd7, 32'h2014, 1'b0);
        write_back(path_alu, 10, $urandom, 32'h0);
        write_back(path_alu, 8, 32'h1, $urandom);
        write_back(path_alu, 9, 32'h1, tgt);
        wait_until(log_flush, 1, "flush of the taken branch");
        check("redirect_pc", tgt, flush_q[0]);
        @(negedge alu_broadcast);
        check("alloc_tag", 0, alloc_tag);
        // predicted taken, falls through
        allocate(OP_BRANCH, 5'd0, 32'h3000, 1'b1);
        write_back(path_alu, 0, 32'h0, $urandom);
        wait_until(log_flush, 2, "flush of the not taken branch");
        check("redirect_pc", 32'h3004, flush_q[1]);
        check("flush count", 2, flush_q.size());
        check("commit count", 21, commit_q.size());
        end_test();

        total = errors + u_rob_top.u_props.fail_count;
        $display("%0d tests run, %0d errors", tests, total);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/rob_props.sv
`include "rob_consts.svh"

module rob_props (
    input logic                  alu_broadcast,
    input logic                  reset,
    input logic                  retire,
    input logic                  reg_we,
    input logic [`ROB_TAG_W-1:0] reg_tag,
    input logic                  flush,
    input logic                  full,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input logic                  wb_ack,
    input logic [`XLEN-1:0]      wb_adr,
    input logic [`XLEN-1:0]      wb_dat_w,
    input logic [3:0]            wb_sel
);

    // failed assertions, read by the testbench at the end
    int fail_count = 0;

    // tag of the oldest entry, one step per retire of any class
    logic [`ROB_TAG_W-1:0] head_tag;

    always_ff @(posedge alu_broadcast) begin
        if (reset || flush) begin
            // flush restarts numbering at zero
            head_tag <= '0;
        end else if (retire) begin
            head_tag <= head_tag + 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge alu_broadcast)
        reset |=> !reg_we && !flush && !wb_cyc && !full)
        else begin fail_count++; $error("retire or bus output active after reset"); end

    // write-only master
    stb_in_cyc: assert property (@(posedge alu_broadcast) disable iff (reset)
        wb_stb |-> wb_cyc && wb_we)
        else begin fail_count++; $error("wb_stb high outside a write cycle"); end

    // classic handshake, request held until ack
    bus_hold: assert property (@(posedge alu_broadcast) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_sel))
        else begin fail_count++; $error("store request changed before ack"); end

    // register write lands one cycle after its entry left the head
    commit_order: assert property (@(posedge alu_broadcast) disable iff (reset)
        reg_we |-> reg_tag == $past(head_tag))
        else begin fail_count++; $error("register commits out of tag order"); end

endmodule

bind rob_top rob_props u_props (
    .alu_broadcast(alu_broadcast), .reset(reset), .retire(retire), .reg_we(reg_we),
    .reg_tag(reg_tag), .flush(flush), .full(full), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel)
);

// File: verilog/rob_top.sv
`include "rob_consts.svh"

module rob_top import rob_pkg::*; (
    input  logic                  alu_broadcast,
    input  logic                  reset,
    // decoder allocation
    input  logic                  alloc_valid,
    input  rob_op_e               alloc_op,
    input  logic [`REG_IDX_W-1:0] alloc_rd,
    input  logic [`XLEN-1:0]      alloc_pc,
    input  logic                  alloc_pred_taken,
    output logic [`ROB_TAG_W-1:0] alloc_tag,
    output logic                  full,
    // decoder operand lookup
    input  logic [`ROB_TAG_W-1:0] rs1_tag,
    input  logic [`ROB_TAG_W-1:0] rs2_tag,
    output logic                  rs1_ready,
    output logic [`XLEN-1:0]      rs1_value,
    output logic                  rs2_ready,
    output logic [`XLEN-1:0]      rs2_value,
    // writeback paths
    input  logic                  alu_valid,
    input  logic [`ROB_TAG_W-1:0] alu_tag,
    input  logic [`XLEN-1:0]      alu_value,
    input  logic [`XLEN-1:0]      alu_target,
    input  logic                  load_valid,
    input  logic [`ROB_TAG_W-1:0] load_tag,
    input  logic [`XLEN-1:0]      load_value,
    input  logic                  store_valid,
    input  logic [`ROB_TAG_W-1:0] store_tag,
    input  logic [`XLEN-1:0]      store_addr,
    input  logic [`XLEN-1:0]      store_data,
    // register commit and redirect
    output logic                  reg_we,
    output logic [`REG_IDX_W-1:0] reg_rd,
    output logic [`XLEN-1:0]      reg_value,
    output logic [`ROB_TAG_W-1:0] reg_tag,
    output logic                  flush,
    output logic [`XLEN-1:0]      redirect_pc,
    // wishbone master, store commit only
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [`XLEN-1:0]      wb_adr,
    output logic [`XLEN-1:0]      wb_dat_w,
    output logic [3:0]            wb_sel,
    input  logic                  wb_ack
);

    logic [`ROB_TAG_W-1:0] head;
    logic [`ROB_CNT_W-1:0] count;
    logic                  alloc_ok;
    logic                  retire;
    logic                  head_ready;
    rob_op_e               head_op;
    logic [`REG_IDX_W-1:0] head_rd;
    logic [`XLEN-1:0]      head_value;
    logic [`XLEN-1:0]      head_pc;
    logic [`XLEN-1:0]      head_target;
    logic [`XLEN-1:0]      head_addr;
    logic                  head_pred_taken;
    logic                  st_req;
    rob_op_e               st_op;
    logic [`XLEN-1:0]      st_addr;
    logic [`XLEN-1:0]      st_data;
    logic                  st_done;

    // tail index is the tag handed to the decoder
    rob_pointers u_pointers (
        .alu_broadcast(alu_broadcast), .reset(reset), .alloc_valid(alloc_valid),
        .retire(retire), .flush(flush), .head(head), .tail(alloc_tag),
        .count(count), .full(full), .alloc_ok(alloc_ok)
    );

    rob_entry_table u_entry_table (
        .alu_broadcast(alu_broadcast), .reset(reset), .alloc_ok(alloc_ok),
        .tail(alloc_tag), .alloc_op(alloc_op), .alloc_rd(alloc_rd),
        .alloc_pc(alloc_pc), .alloc_pred_taken(alloc_pred_taken),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
        .alu_target(alu_target), .load_valid(load_valid), .load_tag(load_tag),
        .load_value(load_value), .store_valid(store_valid), .store_tag(store_tag),
        .store_addr(store_addr), .store_data(store_data), .retire(retire),
        .flush(flush), .head(head), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .rs1_ready(rs1_ready), .rs1_value(rs1_value), .rs2_ready(rs2_ready),
        .rs2_value(rs2_value), .head_ready(head_ready), .head_op(head_op),
        .head_rd(head_rd), .head_value(head_value), .head_pc(head_pc),
        .head_target(head_target), .head_addr(head_addr),
        .head_pred_taken(head_pred_taken)
    );

    rob_retire u_retire (
        .alu_broadcast(alu_broadcast), .reset(reset), .count(count), .head(head),
        .head_ready(head_ready), .head_op(head_op), .head_rd(head_rd),
        .head_value(head_value), .head_pc(head_pc), .head_target(head_target),
        .head_addr(head_addr), .head_pred_taken(head_pred_taken), .st_done(st_done),
        .retire(retire), .flush(flush), .redirect_pc(redirect_pc), .reg_we(reg_we),
        .reg_rd(reg_rd), .reg_value(reg_value), .reg_tag(reg_tag), .st_req(st_req),
        .st_op(st_op), .st_addr(st_addr), .st_data(st_data)
    );

    rob_store_port u_store_port (
        .alu_broadcast(alu_broadcast), .reset(reset), .st_req(st_req), .st_op(st_op),
        .st_addr(st_addr), .st_data(st_data), .wb_ack(wb_ack), .st_done(st_done),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel)
    );

endmodule

// File: verilog/rob_store_port.sv
`include "rob_consts.svh"

module rob_store_port import rob_pkg::*; (
    input  logic             alu_broadcast,
    input  logic             reset,
    input  logic             st_req,
    input  rob_op_e          st_op,
    input  logic [`XLEN-1:0] st_addr,
    input  logic [`XLEN-1:0] st_data,
    input  logic             wb_ack,
    output logic             st_done,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [`XLEN-1:0] wb_adr,
    output logic [`XLEN-1:0] wb_dat_w,
    output logic [3:0]       wb_sel
);

    wb_state_e state;

    always_ff @(posedge alu_broadcast) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (st_req) begin
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    // classic cycle ends on the sampled ack
                    if (wb_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // write-only master, cyc and stb move together
    assign wb_cyc  = (state == ST_BUS);
    assign wb_stb  = (state == ST_BUS);
    assign wb_we   = (state == ST_BUS);
    assign st_done = (state == ST_BUS) && wb_ack;

    // word aligned address
    assign wb_adr = {st_addr[`XLEN-1:2], 2'b00};

    // lane select and data placement by size
    always_comb begin
        case (st_op)
            OP_STORE_B: begin
                wb_sel   = 4'b0001 << st_addr[1:0];
                wb_dat_w = {{(`XLEN-8){1'b0}}, st_data[7:0]} << {st_addr[1:0], 3'b000};
            end
            OP_STORE_H: begin
                wb_sel   = st_addr[1] ? 4'b1100 : 4'b0011;
                wb_dat_w = {{(`XLEN-16){1'b0}}, st_data[15:0]} << {st_addr[1], 4'b0000};
            end
            default: begin
                // word store, all lanes
                wb_sel   = 4'b1111;
                wb_dat_w = st_data;
            end
        endcase
    end

endmodule

// File: verilog/rob_retire.sv
`include "rob_consts.svh"

module rob_retire import rob_pkg::*; (
    input  logic                  alu_broadcast,
    input  logic                  reset,
    input  logic [`ROB_CNT_W-1:0] count,
    input  logic [`ROB_TAG_W-1:0] head,
    input  logic                  head_ready,
    input  rob_op_e               head_op,
    input  logic [`REG_IDX_W-1:0] head_rd,
    input  logic [`XLEN-1:0]      head_value,
    input  logic [`XLEN-1:0]      head_pc,
    input  logic [`XLEN-1:0]      head_target,
    input  logic [`XLEN-1:0]      head_addr,
    input  logic                  head_pred_taken,
    input  logic                  st_done,
    output logic                  retire,
    output logic                  flush,
    output logic [`XLEN-1:0]      redirect_pc,
    output logic                  reg_we,
    output logic [`REG_IDX_W-1:0] reg_rd,
    output logic [`XLEN-1:0]      reg_value,
    output logic [`ROB_TAG_W-1:0] reg_tag,
    output logic                  st_req,
    output rob_op_e               st_op,
    output logic [`XLEN-1:0]      st_addr,
    output logic [`XLEN-1:0]      st_data
);

    logic head_go;
    logic head_is_store;
    logic taken;
    logic mispredict;

    assign head_is_store = (head_op == OP_STORE_B) || (head_op == OP_STORE_H) ||
                           (head_op == OP_STORE_W);

    // head may act this cycle
    // st_req high means a store is still on the bus
    // flush high means younger entries are about to be dropped
    assign head_go = head_ready && (count != '0) && !st_req && !flush;

    // branch outcome from alu value bit 0
    assign taken      = head_value[0];
    assign mispredict = (head_op == OP_BRANCH) && (taken != head_pred_taken);

    // stores leave the head only at the ack edge
    assign retire = (head_go && !head_is_store) || (st_req && st_done);

    always_ff @(posedge alu_broadcast) begin
        if (reset) begin
            reg_we <= 1'b0;
            flush  <= 1'b0;
            st_req <= 1'b0;
        end else begin
            reg_we <= head_go && (head_op == OP_REG);
            // one cycle pulse, head_go is low while flush is up
            flush  <= head_go && mispredict;
            // store request held until the bus acks
            if (st_req && st_done) begin
                st_req <= 1'b0;
            end else if (head_go && head_is_store) begin
                st_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge alu_broadcast) begin
        if (head_go) begin
            reg_rd    <= head_rd;
            reg_value <= head_value;
            reg_tag   <= head;
            // taken goes to the target, not taken falls through
            if (taken) begin
                redirect_pc <= head_target;
            end else begin
                redirect_pc <= head_pc + `XLEN'd4;
            end
        end
        // captured once per store, stable for the whole bus cycle
        if (head_go && head_is_store) begin
            st_op   <= head_op;
            st_addr <= head_addr;
            st_data <= head_value;
        end
    end

endmodule

// File: verilog/rob_entry_table.sv
`include "rob_consts.svh"

module rob_entry_table import rob_pkg::*; (
    input  logic                  alu_broadcast,
    input  logic                  reset,
    input  logic                  alloc_ok,
    input  logic [`ROB_TAG_W-1:0] tail,
    input  rob_op_e               alloc_op,
    input  logic [`REG_IDX_W-1:0] alloc_rd,
    input  logic [`XLEN-1:0]      alloc_pc,
    input  logic                  alloc_pred_taken,
    input  logic                  alu_valid,
    input  logic [`ROB_TAG_W-1:0] alu_tag,
    input  logic [`XLEN-1:0]      alu_value,
    input  logic [`XLEN-1:0]      alu_target,
    input  logic                  load_valid,
    input  logic [`ROB_TAG_W-1:0] load_tag,
    input  logic [`XLEN-1:0]      load_value,
    input  logic                  store_valid,
    input  logic [`ROB_TAG_W-1:0] store_tag,
    input  logic [`XLEN-1:0]      store_addr,
    input  logic [`XLEN-1:0]      store_data,
    input  logic                  retire,
    input  logic                  flush,
    input  logic [`ROB_TAG_W-1:0] head,
    input  logic [`ROB_TAG_W-1:0] rs1_tag,
    input  logic [`ROB_TAG_W-1:0] rs2_tag,
    output logic                  rs1_ready,
    output logic [`XLEN-1:0]      rs1_value,
    output logic                  rs2_ready,
    output logic [`XLEN-1:0]      rs2_value,
    output logic                  head_ready,
    output rob_op_e               head_op,
    output logic [`REG_IDX_W-1:0] head_rd,
    output logic [`XLEN-1:0]      head_value,
    output logic [`XLEN-1:0]      head_pc,
    output logic [`XLEN-1:0]      head_target,
    output logic [`XLEN-1:0]      head_addr,
    output logic                  head_pred_taken
);

    // per-entry descriptor written at allocation
    rob_op_e               op_q     [`ROB_DEPTH];
    logic [`REG_IDX_W-1:0] rd_q     [`ROB_DEPTH];
    logic [`XLEN-1:0]      pc_q     [`ROB_DEPTH];
    logic                  pred_q   [`ROB_DEPTH];
    // results from the writeback paths
    // value doubles as store data, bit 0 is taken for a branch
    logic [`XLEN-1:0]      value_q  [`ROB_DEPTH];
    logic [`XLEN-1:0]      target_q [`ROB_DEPTH];
    logic [`XLEN-1:0]      addr_q   [`ROB_DEPTH];
    // result written and entry not yet retired
    logic [`ROB_DEPTH-1:0] ready_q;

    always_ff @(posedge alu_broadcast) begin
        if (alloc_ok) begin
            op_q[tail]   <= alloc_op;
            rd_q[tail]   <= alloc_rd;
            pc_q[tail]   <= alloc_pc;
            pred_q[tail] <= alloc_pred_taken;
        end
        if (alu_valid) begin
            value_q[alu_tag]  <= alu_value;
            target_q[alu_tag] <= alu_target;
        end
        if (load_valid) begin
            value_q[load_tag] <= load_value;
        end
        if (store_valid) begin
            addr_q[store_tag]  <= store_addr;
            value_q[store_tag] <= store_data;
        end
    end

    always_ff @(posedge alu_broadcast) begin
        if (reset || flush) begin
            ready_q <= '0;
        end else begin
            // clears first, writeback sets win
            if (retire) begin
                ready_q[head] <= 1'b0;
            end
            if (alloc_ok) begin
                ready_q[tail] <= 1'b0;
            end
            if (alu_valid) begin
                ready_q[alu_tag] <= 1'b1;
            end
            if (load_valid) begin
                ready_q[load_tag] <= 1'b1;
            end
            if (store_valid) begin
                ready_q[store_tag] <= 1'b1;
            end
        end
    end

    // decoder operand lookup, no bypass of same-cycle writes
    assign rs1_ready = ready_q[rs1_tag];
    assign rs1_value = value_q[rs1_tag];
    assign rs2_ready = ready_q[rs2_tag];
    assign rs2_value = value_q[rs2_tag];

    // oldest entry, seen by retire
    assign head_ready      = ready_q[head];
    assign head_op         = op_q[head];
    assign head_rd         = rd_q[head];
    assign head_value      = value_q[head];
    assign head_pc         = pc_q[head];
    assign head_target     = target_q[head];
    assign head_addr       = addr_q[head];
    assign head_pred_taken = pred_q[head];

endmodule

// File: verilog/rob_pointers.sv
`include "rob_consts.svh"

module rob_pointers (
    input  logic                  alu_broadcast,
    input  logic                  reset,
    input  logic                  alloc_valid,
    input  logic                  retire,
    input  logic                  flush,
    output logic [`ROB_TAG_W-1:0] head,
    output logic [`ROB_TAG_W-1:0] tail,
    output logic [`ROB_CNT_W-1:0] count,
    output logic                  full,
    output logic                  alloc_ok
);

    // buffer holds all 16 entries
    assign full = (count == `ROB_CNT_W'(`ROB_DEPTH));

    // allocation dropped when full or while flushing
    assign alloc_ok = alloc_valid && !full && !flush;

    always_ff @(posedge alu_broadcast) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // mispredict empties the whole queue
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // tag width matches depth, so pointers wrap by themselves
            if (alloc_ok) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            // alloc and retire in the same cycle cancel out
            count <= count + `ROB_CNT_W'(alloc_ok) - `ROB_CNT_W'(retire);
        end
    end

endmodule

// File: verilog/rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

    // class of a buffer entry
    // decides what retire does with it
    typedef enum logic [2:0] {
        // result goes to the register file
        OP_REG     = 3'd0,
        // stores, one per access size
        OP_STORE_B = 3'd1,
        OP_STORE_H = 3'd2,
        OP_STORE_W = 3'd3,
        // conditional branch, checked against prediction
        OP_BRANCH  = 3'd4
    } rob_op_e;

    // store port bus state
    typedef enum logic {
        // no bus cycle
        ST_IDLE = 1'b0,
        // cyc/stb up, waiting on ack
        ST_BUS  = 1'b1
    } wb_state_e;

endpackage

// File: verilog/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// number of buffer entries
`define ROB_DEPTH 16

// entry tag, indexes the buffer directly
`define ROB_TAG_W 4

// occupancy count, one bit wider so a full buffer reads 16
`define ROB_CNT_W 5

// data and address width
`define XLEN 32

// architectural register index
`define REG_IDX_W 5

`endif
